//--- verilog/soc_bus_pkg.sv
package soc_bus_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  be_t;
    typedef logic [31:0] addr_t;
    typedef logic [15:0] gpio_t;
    typedef logic [3:0]  region_t;

    // ########################################
    // address map
    // ########################################
    localparam int REGION_LSB = 13;
    localparam int REGION_MSB = 16;

    localparam region_t REGION_DATA_RAM  = 4'd0;
    localparam region_t REGION_INSTR_RAM = 4'd2;
    localparam region_t REGION_TIMER     = 4'd6;
    localparam region_t REGION_GPIO      = 4'd8;

    // byte offsets inside a device region, low 5 address bits
    localparam logic [4:0] TIMER_COUNT   = 5'h00;
    localparam logic [4:0] TIMER_COMPARE = 5'h04;
    localparam logic [4:0] TIMER_CTRL    = 5'h08;
    localparam logic [4:0] TIMER_STATUS  = 5'h0C;

    localparam logic [4:0] TIMER_IRQ_ID = 5'd7;

    localparam logic [4:0] GPIO_OUT = 5'h00;
    localparam logic [4:0] GPIO_IN  = 5'h04;

    // replace the enabled bytes of a register word
    function automatic word_t be_merge(word_t old_word, word_t new_word, be_t be);
        word_t merged;
        merged = old_word;
        for (int i = 0; i < 4; i++) begin
            if (be[i])
                merged[8*i +: 8] = new_word[8*i +: 8];
        end
        return merged;
    endfunction

endpackage

//--- verilog/periph_bus_if.sv
interface periph_bus_if;

    logic                               we;      // request, write and region match
    soc_bus_pkg::be_t                   be;
    logic [soc_bus_pkg::REGION_LSB-3:0] offset;  // word offset within the region
    soc_bus_pkg::word_t                 wdata;
    soc_bus_pkg::word_t                 rdata;   // combinational from offset

    modport host (
        output we,
        output be,
        output offset,
        output wdata,
        input  rdata
    );

    modport device (
        input  we,
        input  be,
        input  offset,
        input  wdata,
        output rdata
    );

endinterface

//--- verilog/soc_bus_decode.sv
module soc_bus_decode (
    input  logic                clk_i,
    input  logic                reset_i,

    input  logic                data_req_i,
    input  logic                data_we_i,
    input  soc_bus_pkg::be_t    data_be_i,
    input  soc_bus_pkg::addr_t  data_addr_i,
    input  soc_bus_pkg::word_t  data_wdata_i,
    output logic                data_gnt_o,
    output logic                data_rvalid_o,
    output soc_bus_pkg::word_t  data_rdata_o,

    periph_bus_if.host          dram_o,
    periph_bus_if.host          iram_o,
    periph_bus_if.host          timer_o,
    periph_bus_if.host          gpio_o
);

    soc_bus_pkg::region_t region;
    logic                 we;
    logic                 dram_sel;
    logic                 iram_sel;
    logic                 timer_sel;
    logic                 gpio_sel;
    soc_bus_pkg::word_t   rdata_mux;

    assign data_gnt_o = 1'b1;  // no back-pressure
    assign region     = data_addr_i[soc_bus_pkg::REGION_MSB:soc_bus_pkg::REGION_LSB];
    assign we         = data_req_i & data_we_i;

    // ########################################
    // region decode
    // ########################################
    always_comb begin
        dram_sel  = 1'b0;
        iram_sel  = 1'b0;
        timer_sel = 1'b0;
        gpio_sel  = 1'b0;
        case (region)
            soc_bus_pkg::REGION_DATA_RAM:  dram_sel  = 1'b1;
            soc_bus_pkg::REGION_INSTR_RAM: iram_sel  = 1'b1;
            soc_bus_pkg::REGION_TIMER:     timer_sel = 1'b1;
            soc_bus_pkg::REGION_GPIO:      gpio_sel  = 1'b1;
            default: ;                                  // unmapped
        endcase
    end

    // every device sees the same request fields, only the strobe is gated
    assign dram_o.we      = we & dram_sel;
    assign dram_o.be      = data_be_i;
    assign dram_o.offset  = data_addr_i[soc_bus_pkg::REGION_LSB-1:2];
    assign dram_o.wdata   = data_wdata_i;

    assign iram_o.we      = we & iram_sel;
    assign iram_o.be      = data_be_i;
    assign iram_o.offset  = data_addr_i[soc_bus_pkg::REGION_LSB-1:2];
    assign iram_o.wdata   = data_wdata_i;

    assign timer_o.we     = we & timer_sel;
    assign timer_o.be     = data_be_i;
    assign timer_o.offset = data_addr_i[soc_bus_pkg::REGION_LSB-1:2];
    assign timer_o.wdata  = data_wdata_i;

    assign gpio_o.we      = we & gpio_sel;
    assign gpio_o.be      = data_be_i;
    assign gpio_o.offset  = data_addr_i[soc_bus_pkg::REGION_LSB-1:2];
    assign gpio_o.wdata   = data_wdata_i;

    // ########################################
    // read path
    // ########################################
    // instr ram drives zero here, so region 2 reads back zero
    assign rdata_mux = ({32{dram_sel}}  & dram_o.rdata)
                     | ({32{iram_sel}}  & iram_o.rdata)
                     | ({32{timer_sel}} & timer_o.rdata)
                     | ({32{gpio_sel}}  & gpio_o.rdata);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            data_rvalid_o <= 1'b0;
        end else begin
            data_rvalid_o <= data_req_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (data_req_i)
            data_rdata_o <= rdata_mux;  // old value on read-during-write
    end

endmodule

//--- verilog/data_ram.sv
module data_ram #(
    parameter int DATA_WORDS = 2048
) (
    input  logic         clk_i,
    periph_bus_if.device bus_i
);

    localparam int AW = $clog2(DATA_WORDS);

    soc_bus_pkg::word_t mem [DATA_WORDS];
    logic [AW-1:0]      addr;

    assign addr = bus_i.offset[AW-1:0];

    // byte lanes written independently
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < 4; i++) begin
            if (bus_i.we && bus_i.be[i])
                mem[addr][8*i +: 8] <= bus_i.wdata[8*i +: 8];
        end
    end

    assign bus_i.rdata = mem[addr];  // async read, registered in the decoder

endmodule

//--- verilog/instr_ram.sv
module instr_ram #(
    parameter int INSTR_WORDS = 2048
) (
    input  logic                clk_i,
    input  logic                reset_i,
    periph_bus_if.device        bus_i,

    input  logic                instr_req_i,
    input  soc_bus_pkg::addr_t  instr_addr_i,
    output logic                instr_gnt_o,
    output logic                instr_rvalid_o,
    output soc_bus_pkg::word_t  instr_rdata_o
);

    localparam int AW = $clog2(INSTR_WORDS);

    soc_bus_pkg::word_t mem [INSTR_WORDS];
    logic [AW-1:0]      load_addr;
    logic [AW-1:0]      fetch_addr;

    assign load_addr  = bus_i.offset[AW-1:0];
    assign fetch_addr = instr_addr_i[AW+1:2];  // byte address to word index

    // loader path, whole words only
    always_ff @(posedge clk_i) begin
        if (bus_i.we)
            mem[load_addr] <= bus_i.wdata;
    end

    assign bus_i.rdata = '0;  // write-only from the data side

    // ########################################
    // fetch port
    // ########################################
    assign instr_gnt_o = 1'b1;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            instr_rvalid_o <= 1'b0;
        end else begin
            instr_rvalid_o <= instr_req_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (instr_req_i)
            instr_rdata_o <= mem[fetch_addr];
    end

endmodule

//--- verilog/timer_irq.sv
module timer_irq (
    input  logic         clk_i,
    input  logic         reset_i,
    periph_bus_if.device bus_i,

    output logic         irq_o,
    input  logic         irq_ack_i,
    input  logic [4:0]   irq_id_i
);

    soc_bus_pkg::word_t count_q;
    soc_bus_pkg::word_t compare_q;
    soc_bus_pkg::word_t ctrl_q;
    logic               pending_q;
    logic [4:0]         reg_off;
    logic               ack_hit;
    logic               match;

    assign reg_off = {bus_i.offset[2:0], 2'b00};
    assign ack_hit = irq_ack_i && (irq_id_i == soc_bus_pkg::TIMER_IRQ_ID);
    assign match   = ctrl_q[0] && (count_q == compare_q);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            count_q   <= '0;
            compare_q <= '0;
            ctrl_q    <= '0;
            pending_q <= 1'b0;
        end else begin
            if (ack_hit)
                pending_q <= 1'b0;

            // a new match wins over an ack in the same cycle
            if (match) begin
                count_q   <= '0;
                pending_q <= 1'b1;
            end else if (ctrl_q[0]) begin
                count_q <= count_q + 32'd1;
            end

            if (bus_i.we) begin
                case (reg_off)
                    soc_bus_pkg::TIMER_COUNT:
                        count_q <= soc_bus_pkg::be_merge(count_q, bus_i.wdata, bus_i.be);
                    soc_bus_pkg::TIMER_COMPARE:
                        compare_q <= soc_bus_pkg::be_merge(compare_q, bus_i.wdata, bus_i.be);
                    soc_bus_pkg::TIMER_CTRL:
                        ctrl_q <= soc_bus_pkg::be_merge(ctrl_q, bus_i.wdata, bus_i.be);
                    default: ;  // status is read-only
                endcase
            end
        end
    end

    // ########################################
    // register read
    // ########################################
    always_comb begin
        case (reg_off)
            soc_bus_pkg::TIMER_COUNT:   bus_i.rdata = count_q;
            soc_bus_pkg::TIMER_COMPARE: bus_i.rdata = compare_q;
            soc_bus_pkg::TIMER_CTRL:    bus_i.rdata = ctrl_q;
            soc_bus_pkg::TIMER_STATUS:  bus_i.rdata = {31'b0, pending_q};
            default:                    bus_i.rdata = '0;
        endcase
    end

    assign irq_o = pending_q;  // level, held until acked

endmodule

//--- verilog/gpio_port.sv
module gpio_port (
    input  logic               clk_i,
    input  logic               reset_i,
    periph_bus_if.device       bus_i,

    input  soc_bus_pkg::gpio_t gpio_in_i,
    output soc_bus_pkg::gpio_t gpio_out_o
);

    soc_bus_pkg::gpio_t out_q;
    soc_bus_pkg::gpio_t in_meta_q;
    soc_bus_pkg::gpio_t in_sync_q;
    logic [4:0]         reg_off;

    assign reg_off = {bus_i.offset[2:0], 2'b00};

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            out_q <= '0;
        end else if (bus_i.we && reg_off == soc_bus_pkg::GPIO_OUT) begin
            // upper two byte enables fall off in the cast
            out_q <= soc_bus_pkg::gpio_t'(soc_bus_pkg::be_merge(
                         soc_bus_pkg::word_t'(out_q), bus_i.wdata, bus_i.be));
        end
    end

    // two-flop synchronizer on the pins
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            in_meta_q <= '0;
            in_sync_q <= '0;
        end else begin
            in_meta_q <= gpio_in_i;
            in_sync_q <= in_meta_q;
        end
    end

    always_comb begin
        case (reg_off)
            soc_bus_pkg::GPIO_OUT: bus_i.rdata = {16'b0, out_q};
            soc_bus_pkg::GPIO_IN:  bus_i.rdata = {16'b0, in_sync_q};
            default:               bus_i.rdata = '0;
        endcase
    end

    assign gpio_out_o = out_q;

endmodule

//--- verilog/soc_periph.sv
module soc_periph #(
    parameter int DATA_WORDS  = 2048,
    parameter int INSTR_WORDS = 2048
) (
    input  logic                clk_i,
    input  logic                reset_i,

    // data bus
    input  logic                data_req_i,
    input  logic                data_we_i,
    input  soc_bus_pkg::be_t    data_be_i,
    input  soc_bus_pkg::addr_t  data_addr_i,
    input  soc_bus_pkg::word_t  data_wdata_i,
    output logic                data_gnt_o,
    output logic                data_rvalid_o,
    output soc_bus_pkg::word_t  data_rdata_o,

    // instruction fetch
    input  logic                instr_req_i,
    input  soc_bus_pkg::addr_t  instr_addr_i,
    output logic                instr_gnt_o,
    output logic                instr_rvalid_o,
    output soc_bus_pkg::word_t  instr_rdata_o,

    output logic                irq_o,
    input  logic                irq_ack_i,
    input  logic [4:0]          irq_id_i,

    input  soc_bus_pkg::gpio_t  gpio_in_i,
    output soc_bus_pkg::gpio_t  gpio_out_o
);

    periph_bus_if dram_bus ();
    periph_bus_if iram_bus ();
    periph_bus_if timer_bus ();
    periph_bus_if gpio_bus ();

    soc_bus_decode soc_bus_decode_i (
        .clk_i, .reset_i,
        .data_req_i, .data_we_i, .data_be_i, .data_addr_i, .data_wdata_i,
        .data_gnt_o, .data_rvalid_o, .data_rdata_o,
        .dram_o  (dram_bus.host),
        .iram_o  (iram_bus.host),
        .timer_o (timer_bus.host),
        .gpio_o  (gpio_bus.host)
    );

    data_ram #(.DATA_WORDS(DATA_WORDS)) data_ram_i (
        .clk_i,
        .bus_i (dram_bus.device)
    );

    instr_ram #(.INSTR_WORDS(INSTR_WORDS)) instr_ram_i (
        .clk_i, .reset_i,
        .bus_i (iram_bus.device),
        .instr_req_i, .instr_addr_i, .instr_gnt_o, .instr_rvalid_o, .instr_rdata_o
    );

    timer_irq timer_irq_i (
        .clk_i, .reset_i,
        .bus_i (timer_bus.device),
        .irq_o, .irq_ack_i, .irq_id_i
    );

    gpio_port gpio_port_i (
        .clk_i, .reset_i,
        .bus_i (gpio_bus.device),
        .gpio_in_i, .gpio_out_o
    );

endmodule

//--- dv/soc_periph_properties.sv
module soc_periph_properties (
    input logic       clk_i,
    input logic       reset_i,
    input logic       data_req_i,
    input logic       data_gnt_o,
    input logic       data_rvalid_o,
    input logic       instr_req_i,
    input logic       instr_gnt_o,
    input logic       instr_rvalid_o,
    input logic       irq_o,
    input logic       irq_ack_i,
    input logic [4:0] irq_id_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // no back-pressure on either port
    gnt_high: assert property (@(posedge clk_i) data_gnt_o && instr_gnt_o)
        else $error("grant dropped");

    data_rvalid_delay: assert property (@(posedge clk_i) disable iff (reset_i)
        data_rvalid_o == $past(data_req_i)) else $error("data_rvalid_o off by a cycle");

    instr_rvalid_delay: assert property (@(posedge clk_i) disable iff (reset_i)
        instr_rvalid_o == $past(instr_req_i)) else $error("instr_rvalid_o off by a cycle");

    // only an ack with the timer id may clear the line
    irq_fall_on_ack: assert property (@(posedge clk_i) disable iff (reset_i)
        $fell(irq_o) |-> $past(irq_ack_i && irq_id_i == 5'd7))
        else $error("irq_o fell without an ack for id 7");

endmodule

bind soc_periph soc_periph_properties soc_periph_properties_i (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .data_req_i     (data_req_i),
    .data_gnt_o     (data_gnt_o),
    .data_rvalid_o  (data_rvalid_o),
    .instr_req_i    (instr_req_i),
    .instr_gnt_o    (instr_gnt_o),
    .instr_rvalid_o (instr_rvalid_o),
    .irq_o          (irq_o),
    .irq_ack_i      (irq_ack_i),
    .irq_id_i       (irq_id_i)
);

//--- dv/soc_periph_tb.sv
module soc_periph_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_DWORDS   = 64;
    localparam int N_IWORDS   = 32;
    localparam int TIMER_CMP  = 600;
    localparam int MAX_CYCLES = 4000;  // tests need about 1300 cycles

    logic                clk_i;
    logic                reset_i;
    logic                data_req_i;
    logic                data_we_i;
    soc_bus_pkg::be_t    data_be_i;
    soc_bus_pkg::addr_t  data_addr_i;
    soc_bus_pkg::word_t  data_wdata_i;
    logic                data_gnt_o;
    logic                data_rvalid_o;
    soc_bus_pkg::word_t  data_rdata_o;
    logic                instr_req_i;
    soc_bus_pkg::addr_t  instr_addr_i;
    logic                instr_gnt_o;
    logic                instr_rvalid_o;
    soc_bus_pkg::word_t  instr_rdata_o;
    logic                irq_o;
    logic                irq_ack_i;
    logic [4:0]          irq_id_i;
    soc_bus_pkg::gpio_t  gpio_in_i;
    soc_bus_pkg::gpio_t  gpio_out_o;

    int errors = 0;
    int cycles = 0;
    int seed   = 96427;
    soc_bus_pkg::word_t dmem_model [N_DWORDS];
    soc_bus_pkg::word_t imem_model [N_IWORDS];

    soc_periph soc_periph_i (.*);

    always #5 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("error: run stopped by timeout after %0d cycles", cycles);
            $display("Something failed");
            $finish;
        end
    end

    // ########################################
    // models and compares
    // ########################################
    function automatic soc_bus_pkg::addr_t reg_addr(soc_bus_pkg::region_t region, int offset);
        return (soc_bus_pkg::addr_t'(region) << 13) | soc_bus_pkg::addr_t'(offset);
    endfunction

    function automatic soc_bus_pkg::word_t merge_bytes(soc_bus_pkg::word_t old_word,
                                                       soc_bus_pkg::word_t new_word,
                                                       soc_bus_pkg::be_t be);
        soc_bus_pkg::word_t mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    task automatic check_word(string name, soc_bus_pkg::word_t got, soc_bus_pkg::word_t exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_gpio(string name, soc_bus_pkg::gpio_t got, soc_bus_pkg::gpio_t exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // ########################################
    // bus drivers
    // ########################################
    task automatic bus_write(soc_bus_pkg::addr_t addr, soc_bus_pkg::word_t data,
                             soc_bus_pkg::be_t be);
        @(posedge clk_i);
        data_req_i   <= 1'b1;
        data_we_i    <= 1'b1;
        data_addr_i  <= addr;
        data_wdata_i <= data;
        data_be_i    <= be;
        @(posedge clk_i);
        data_req_i <= 1'b0;
        data_we_i  <= 1'b0;
    endtask

    task automatic bus_read(soc_bus_pkg::addr_t addr, output soc_bus_pkg::word_t data);
        int waited;
        @(posedge clk_i);
        data_req_i  <= 1'b1;
        data_we_i   <= 1'b0;
        data_addr_i <= addr;
        data_be_i   <= 4'hf;
        @(posedge clk_i);
        data_req_i <= 1'b0;
        waited = 0;
        @(negedge clk_i);
        while (!data_rvalid_o && waited < 4) begin
            @(negedge clk_i);
            waited++;
        end
        if (!data_rvalid_o) begin
            errors++;
            $display("error: data_rvalid_o never rose for the read at %h", addr);
        end
        data = data_rdata_o;
        check_bit("data_gnt_o", data_gnt_o, 1'b1);
    endtask

    task automatic fetch(soc_bus_pkg::addr_t addr, output soc_bus_pkg::word_t data);
        int waited;
        @(posedge clk_i);
        instr_req_i  <= 1'b1;
        instr_addr_i <= addr;
        @(posedge clk_i);
        instr_req_i <= 1'b0;
        waited = 0;
        @(negedge clk_i);
        while (!instr_rvalid_o && waited < 4) begin
            @(negedge clk_i);
            waited++;
        end
        if (!instr_rvalid_o) begin
            errors++;
            $display("error: instr_rvalid_o never rose for the fetch at %h", addr);
        end
        data = instr_rdata_o;
        check_bit("instr_gnt_o", instr_gnt_o, 1'b1);
    endtask

    task automatic ack_irq(logic [4:0] id);
        @(posedge clk_i);
        irq_ack_i <= 1'b1;
        irq_id_i  <= id;
        @(posedge clk_i);
        irq_ack_i <= 1'b0;
        @(negedge clk_i);
    endtask

    // ########################################
    // directed tests
    // ########################################
    task automatic test_data_ram();
        soc_bus_pkg::word_t data;
        soc_bus_pkg::word_t got;
        soc_bus_pkg::be_t   be;
        for (int i = 0; i < N_DWORDS; i++) begin  // full words first, ram has no reset
            data = $random(seed);
            dmem_model[i] = data;
            bus_write(reg_addr(soc_bus_pkg::REGION_DATA_RAM, 4*i), data, 4'hf);
        end
        for (int i = 0; i < N_DWORDS; i++) begin
            data = $random(seed);
            be   = soc_bus_pkg::be_t'($random(seed));
            dmem_model[i] = merge_bytes(dmem_model[i], data, be);
            bus_write(reg_addr(soc_bus_pkg::REGION_DATA_RAM, 4*i), data, be);
        end
        for (int i = 0; i < N_DWORDS; i++) begin
            bus_read(reg_addr(soc_bus_pkg::REGION_DATA_RAM, 4*i), got);
            check_word("data_rdata_o", got, dmem_model[i]);
        end
    endtask

    task automatic test_instr_ram();
        soc_bus_pkg::word_t data;
        soc_bus_pkg::word_t got;
        for (int i = 0; i < N_IWORDS; i++) begin
            data = $random(seed);
            imem_model[i] = data;
            bus_write(reg_addr(soc_bus_pkg::REGION_INSTR_RAM, 4*i), data, 4'hf);
        end
        for (int i = 0; i < N_IWORDS; i++) begin
            fetch(soc_bus_pkg::addr_t'(4*i), got);
            check_word("instr_rdata_o", got, imem_model[i]);
        end
        bus_read(reg_addr(soc_bus_pkg::REGION_INSTR_RAM, 0), got);  // write-only region
        check_word("data_rdata_o", got, '0);
    endtask

    task automatic test_unmapped();
        soc_bus_pkg::word_t data;
        soc_bus_pkg::word_t got;
        bus_write(reg_addr(soc_bus_pkg::REGION_GPIO, int'(soc_bus_pkg::GPIO_OUT)),
                  32'h0000_a5c3, 4'hf);
        for (int r = 0; r < 16; r++) begin
            if (r == 0 || r == 2 || r == 6 || r == 8)
                continue;
            data = $random(seed);
            bus_write(reg_addr(soc_bus_pkg::region_t'(r), 0), data, 4'hf);
            bus_read(reg_addr(soc_bus_pkg::region_t'(r), 0), got);
            check_word("data_rdata_o", got, '0);
        end
        bus_read(reg_addr(soc_bus_pkg::REGION_DATA_RAM, 0), got);
        check_word("data_rdata_o", got, dmem_model[0]);
        check_gpio("gpio_out_o", gpio_out_o, 16'ha5c3);
    endtask

    task automatic test_gpio();
        soc_bus_pkg::word_t data;
        soc_bus_pkg::word_t got;
        soc_bus_pkg::gpio_t out_exp;
        soc_bus_pkg::gpio_t in_val;
        out_exp = 16'ha5c3;
        data = $random(seed);
        bus_write(reg_addr(soc_bus_pkg::REGION_GPIO, int'(soc_bus_pkg::GPIO_OUT)), data, 4'b0010);
        out_exp[15:8] = data[15:8];
        @(negedge clk_i);
        check_gpio("gpio_out_o", gpio_out_o, out_exp);
        data = $random(seed);
        bus_write(reg_addr(soc_bus_pkg::REGION_GPIO, int'(soc_bus_pkg::GPIO_OUT)), data, 4'b1101);
        out_exp[7:0] = data[7:0];  // enables 3 and 2 have no byte to hit
        @(negedge clk_i);
        check_gpio("gpio_out_o", gpio_out_o, out_exp);
        data   = $random(seed);
        in_val = data[15:0];
        @(posedge clk_i);
        gpio_in_i <= in_val;
        repeat (3) @(posedge clk_i);
        bus_read(reg_addr(soc_bus_pkg::REGION_GPIO, int'(soc_bus_pkg::GPIO_IN)), got);
        check_word("data_rdata_o", got, {16'h0, in_val});
    endtask

    task automatic test_timer();
        soc_bus_pkg::word_t got;
        int waited;
        bus_write(reg_addr(soc_bus_pkg::REGION_TIMER, int'(soc_bus_pkg::TIMER_COMPARE)),
                  soc_bus_pkg::word_t'(TIMER_CMP), 4'hf);
        bus_write(reg_addr(soc_bus_pkg::REGION_TIMER, int'(soc_bus_pkg::TIMER_CTRL)),
                  32'h1, 4'hf);
        waited = 0;
        @(negedge clk_i);
        while (!irq_o && waited < TIMER_CMP + 3) begin
            @(negedge clk_i);
            waited++;
        end
        if (!irq_o) begin
            errors++;
            $display("error: irq_o did not rise within %0d cycles", TIMER_CMP + 3);
        end
        bus_read(reg_addr(soc_bus_pkg::REGION_TIMER, int'(soc_bus_pkg::TIMER_STATUS)), got);
        check_word("data_rdata_o", got, 32'h1);
        ack_irq(5'd3);  // wrong id, line stays up
        check_bit("irq_o", irq_o, 1'b1);
        bus_write(reg_addr(soc_bus_pkg::REGION_TIMER, int'(soc_bus_pkg::TIMER_CTRL)),
                  32'h0, 4'hf);
        ack_irq(5'd7);
        check_bit("irq_o", irq_o, 1'b0);
        bus_read(reg_addr(soc_bus_pkg::REGION_TIMER, int'(soc_bus_pkg::TIMER_STATUS)), got);
        check_word("data_rdata_o", got, 32'h0);
    endtask

    initial begin
        clk_i        = 1'b0;
        reset_i      = 1'b1;
        data_req_i   = 1'b0;
        data_we_i    = 1'b0;
        data_be_i    = '0;
        data_addr_i  = '0;
        data_wdata_i = '0;
        instr_req_i  = 1'b0;
        instr_addr_i = '0;
        irq_ack_i    = 1'b0;
        irq_id_i     = '0;
        gpio_in_i    = '0;
        repeat (2) @(posedge clk_i);
        reset_i <= 1'b0;
        test_data_ram();
        test_instr_ram();
        test_unmapped();
        test_gpio();
        test_timer();
        repeat (2) @(posedge clk_i);
        $display("checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- soc_periph.f
verilog/soc_bus_pkg.sv
verilog/periph_bus_if.sv
verilog/soc_bus_decode.sv
verilog/data_ram.sv
verilog/instr_ram.sv
verilog/timer_irq.sv
verilog/gpio_port.sv
verilog/soc_periph.sv
dv/soc_periph_properties.sv
dv/soc_periph_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = soc_periph_tb
FILELIST = soc_periph.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "^Everything OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
